//--- bench/alu_assertions.sv
`timescale 1ns/1ps

module alu_assertions (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic out_valid,
  input logic flags_we
);

  int failures = 0; // failed assertions so far

  // first cycle out of reset
  property quiet_after_reset;
    @(posedge clk) $fell(rst) |-> !out_valid && !flags_we;
  endproperty

  property we_needs_valid;
    @(posedge clk) disable iff (rst) flags_we |-> out_valid;
  endproperty

  property valid_follows_issue;
    @(posedge clk) disable iff (rst) out_valid |-> $past(in_valid);
  endproperty

  a_quiet: assert property (quiet_after_reset) else begin
    $error("output valid right after reset");
    failures++;
  end
  a_we: assert property (we_needs_valid) else begin
    $error("flag write without valid output");
    failures++;
  end
  a_issue: assert property (valid_follows_issue) else begin
    $error("valid output with no issue");
    failures++;
  end

endmodule

bind alu_top alu_assertions asrt0 (
  .clk(clk), .rst(rst), .in_valid(in_valid), .out_valid(out_valid), .flags_we(flags_we)
);

//--- bench/alu_clock_gen.sv
`timescale 1ns/1ps

module alu_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- bench/alu_tb.sv
`timescale 1ns/1ps

module alu_tb import alu_types_pkg::*, alu_ops_pkg::*; ;

  typedef struct {
    logic    valid;
    op_t     op;
    width_t  width;
    cond_t   cond;
    flags_t  fl;
    word_t   a;
    word_t   b;
    logic    rnd;
    thread_t th;
    logic    exc;
    thread_t eth;
  } row_t;

  typedef struct {
    logic   valid;
    word_t  res;
    flags_t fl;
    logic   we;
  } exp_t;

  logic clk, rst, in_valid, except, out_valid, flags_we;
  op_t op;
  width_t width;
  cond_t cond;
  word_t a, b, result;
  flags_t flags_in, flags_out;
  thread_t thread, except_thread;

  row_t rows_q[$];
  exp_t exp_q[$];
  int errors = 0;
  logic rows_ready = 1'b0;
  logic [31:0] lfsr_state = 32'h186f;

  alu_clock_gen clkgen0 (.clk(clk), .rst(rst));

  alu_top dut0 (
    .clk(clk), .rst(rst), .in_valid(in_valid), .op(op), .width(width), .cond(cond),
    .a(a), .b(b), .flags_in(flags_in), .thread(thread), .except(except),
    .except_thread(except_thread), .out_valid(out_valid), .result(result),
    .flags_out(flags_out), .flags_we(flags_we)
  );

  // galois lfsr stepped once per random bit
  function word_t rand_word();
    word_t w;
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      w[i] = lfsr_state[0];
    end
    return w;
  endfunction

  task automatic add_row(op_t o, width_t w, cond_t c, flags_t f, word_t x, word_t y,
                         logic rnd, thread_t th = 0, logic exc = 0, thread_t eth = 0,
                         logic valid = 1'b1);
    row_t r;
    r = '{valid, o, w, c, f, x, y, rnd, th, exc, eth};
    rows_q.push_back(r);
  endtask

  function automatic logic cond_true(cond_t c, flags_t f);
    logic cf, of, sf, zf, pf, t;
    cf = f[FLAG_C];
    of = f[FLAG_O];
    sf = f[FLAG_S];
    zf = f[FLAG_Z];
    pf = f[FLAG_P];
    case (c[3:1]) // base condition from the upper bits
      3'd0: t = zf;
      3'd1: t = sf;
      3'd2: t = !cf && !zf;
      3'd3: t = !cf;
      3'd4: t = (sf == of) && !zf;
      3'd5: t = (sf == of);
      3'd6: t = of;
      default: t = pf;
    endcase
    return c[0] ? !t : t; // odd codes invert
  endfunction

  // expected result, flags and flag write for one row
  function automatic void model(row_t r, output word_t res, output flags_t f, output logic we);
    int n;
    word_t mask, raw;
    logic [64:0] full;
    logic sa, sb, cf, af, of;
    n = 8 << r.width;
    mask = (n == 64) ? '1 : ((64'd1 << n) - 1);
    sa = r.a[n-1];
    sb = r.b[n-1];
    cf = 1'b0;
    af = 1'b0;
    raw = '0;
    case (r.op)
      OP_ADD: begin
        full = {1'b0, r.a & mask} + {1'b0, r.b & mask};
        raw = full[63:0];
        cf = full[n];
        af = ({1'b0, r.a[3:0]} + {1'b0, r.b[3:0]}) > 5'd15;
      end
      OP_SUB: begin
        raw = (r.a & mask) - (r.b & mask);
        cf = (r.a & mask) < (r.b & mask);
        af = r.a[3:0] < r.b[3:0];
      end
      OP_AND:  raw = r.a & r.b;
      OP_OR:   raw = r.a | r.b;
      OP_XOR:  raw = r.a ^ r.b;
      OP_MOV:  raw = r.b;
      OP_CMOV: raw = cond_true(r.cond, r.fl) ? r.b : r.a;
      default: raw = '0;
    endcase
    of = (r.op == OP_ADD) ? (sa == sb && raw[n-1] != sa) :
         (r.op == OP_SUB) ? (sa != sb && raw[n-1] != sa) : 1'b0;
    if (r.op <= OP_MOV || r.op == OP_CMOV)
      res = (r.width == W32) ? (raw & mask) : ((r.a & ~mask) | (raw & mask));
    else if (r.op == OP_ZXT)
      res = r.b & mask;
    else if (r.op == OP_SXT)
      res = sb ? (r.b | ~mask) : (r.b & mask);
    else if (r.op == OP_CSET)
      res = {63'b0, cond_true(r.cond, r.fl)};
    else
      res = '0;
    f = {cf, of, af, res[n-1], (res & mask) == '0, ~^res[7:0]};
    we = (r.op <= OP_XOR);
  endfunction

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flags(string name, flags_t got, flags_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_outputs(exp_t e);
    check_bit("out_valid", out_valid, e.valid);
    check_bit("flags_we", flags_we, e.we);
    if (e.valid) begin
      check_word("result", result, e.res);
      if (e.we)
        check_flags("flags_out", flags_out, e.fl);
    end
  endtask

  task automatic build_table();
    flags_t fsets[4];
    fsets = '{6'b000000, 6'b110010, 6'b001000, 6'b100101};
    for (int w = 0; w < 4; w++) begin
      add_row(OP_ADD, width_t'(w), CC_Z, 0, 0, 0, 1);
      add_row(OP_SUB, width_t'(w), CC_Z, 0, 0, 0, 1);
    end
    add_row(OP_ADD, W8, CC_Z, 0, 64'h1234_00ff, 64'h1, 0);   // carry, zero
    add_row(OP_ADD, W8, CC_Z, 0, 64'h7f, 64'h1, 0);          // overflow
    add_row(OP_ADD, W8, CC_Z, 0, 64'h0f, 64'h1, 0);          // nibble carry
    add_row(OP_SUB, W16, CC_Z, 0, 64'habcd_0000, 64'h1, 0);
    add_row(OP_SUB, W32, CC_Z, 0, 64'h8000_0000, 64'h1, 0);
    add_row(OP_ADD, W64, CC_Z, 0, '1, 64'h1, 0);
    add_row(OP_SUB, W64, CC_Z, 0, 64'h5, 64'h5, 0);
    for (int w = 0; w < 4; w++) begin
      add_row(OP_AND, width_t'(w), CC_Z, 0, 0, 0, 1);
      add_row(OP_OR, width_t'(w), CC_Z, 0, 0, 0, 1);
      add_row(OP_XOR, width_t'(w), CC_Z, 0, 0, 0, 1);
      add_row(OP_MOV, width_t'(w), CC_Z, 0, 0, 0, 1);
      add_row(OP_ZXT, width_t'(w), CC_Z, 0, 0, 0, 1);
      add_row(OP_SXT, width_t'(w), CC_Z, 0, 0, 0, 1);
    end
    add_row(OP_SXT, W8, CC_Z, 0, 0, 64'h80, 0);
    add_row(OP_MOV, W64, CC_Z, 0, 0, 0, 0, 0, 0, 0, 0); // idle cycle
    for (int c = 0; c < 16; c++) begin
      add_row(OP_CMOV, (c % 3 == 0) ? W32 : W64, cond_t'(c), fsets[c % 4], 0, 0, 1);
      add_row(OP_CSET, W64, cond_t'(c), fsets[(c + 1) % 4], 0, 0, 1);
    end
    add_row(OP_ADD, W64, CC_Z, 0, 0, 0, 1, 0, 1, 0); // killed now
    add_row(OP_ADD, W64, CC_Z, 0, 0, 0, 1, 0, 0, 0); // killed by last cycle
    add_row(OP_ADD, W64, CC_Z, 0, 0, 0, 1, 1, 1, 0); // other thread survives
    add_row(OP_XOR, W32, CC_Z, 0, 0, 0, 1, 1, 0, 0);
    add_row(OP_ADD, W64, CC_Z, 0, 0, 0, 0, 0, 1, 0, 0); // idle cycle with an exception
    add_row(OP_AND, W64, CC_Z, 0, 0, 0, 1, 0, 0, 0);    // killed by the idle cycle
    add_row(OP_SUB, W16, CC_Z, 0, 0, 0, 1, 0, 0, 0);
  endtask

  initial begin
    in_valid = 0;
    op = OP_ADD;
    width = W64;
    cond = CC_Z;
    a = '0;
    b = '0;
    flags_in = '0;
    thread = 0;
    except = 0;
    except_thread = 0;
  end

  initial begin
    wait (rows_ready);
    #((rows_q.size() + 16 + 10) * 8);
    $display("Timeout: the run did not finish in the expected time");
    $display("Verification failed");
    $finish;
  end

  initial begin
    row_t r;
    exp_t e;
    word_t res;
    flags_t fl;
    logic we, kill, prev_exc;
    thread_t prev_th;
    prev_exc = 1'b0;
    prev_th = 0;
    build_table();
    rows_ready = 1'b1;
    @(negedge clk);
    while (rst) @(negedge clk);
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("flags_we", flags_we, 1'b0);
    for (int i = 0; i < rows_q.size(); i++) begin
      r = rows_q[i];
      if (r.rnd) begin
        r.a = rand_word();
        r.b = rand_word();
      end
      @(posedge clk);
      in_valid <= r.valid;
      op <= r.op;
      width <= r.width;
      cond <= r.cond;
      flags_in <= r.fl;
      a <= r.a;
      b <= r.b;
      thread <= r.th;
      except <= r.exc;
      except_thread <= r.eth;
      model(r, res, fl, we);
      kill = (r.exc && r.eth == r.th) || (prev_exc && prev_th == r.th);
      e = '{r.valid && !kill, res, fl, r.valid && !kill && we};
      prev_exc = r.exc;
      prev_th = r.eth;
      exp_q.push_back(e);
      @(negedge clk);
      if (exp_q.size() > 1)
        compare_outputs(exp_q.pop_front());
    end
    @(posedge clk);
    in_valid <= 1'b0;
    except <= 1'b0;
    @(negedge clk);
    compare_outputs(exp_q.pop_front());
    errors += dut0.asrt0.failures;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- project.f
source/alu_types_pkg.sv
source/alu_ops_pkg.sv
source/alu_adder.sv
source/cond_eval.sv
source/alu_result_select.sv
source/alu_retire_stage.sv
source/flag_gen.sv
source/alu_top.sv
bench/alu_clock_gen.sv
bench/alu_assertions.sv
bench/alu_tb.sv

//--- source/alu_adder.sv
`timescale 1ns/1ps

module alu_adder import alu_types_pkg::*; (
  input  word_t  a,
  input  word_t  b,
  input  logic   sub,
  output word_t  sum,
  output carry_t carry,
  output ovf_t   ovf
);

  word_t b_eff;
  word_t cin_bits; // carry into each bit
  logic  cout;

  // subtract as a + ~b + 1
  assign b_eff = sub ? ~b : b;

  assign {cout, sum} = {1'b0, a} + {1'b0, b_eff} + {{WORD_W{1'b0}}, sub};

  // sum bit = a ^ b ^ carry in, so the carries fall out of the sum
  assign cin_bits = a ^ b_eff ^ sum;

  assign carry[CY_NIB] = cin_bits[4];
  assign carry[CY_8]   = cin_bits[8];
  assign carry[CY_16]  = cin_bits[16];
  assign carry[CY_32]  = cin_bits[32];
  assign carry[CY_64]  = cout;

  // overflow when carry into the sign bit differs from carry out of it
  assign ovf[0] = cin_bits[7] ^ cin_bits[8];
  assign ovf[1] = cin_bits[15] ^ cin_bits[16];
  assign ovf[2] = cin_bits[31] ^ cin_bits[32];
  assign ovf[3] = cin_bits[63] ^ cout;

endmodule

//--- source/alu_ops_pkg.sv
package alu_ops_pkg;

  localparam int OP_W    = 4;
  localparam int WIDTH_W = 2;
  localparam int COND_W  = 4;

  typedef logic [OP_W-1:0]    op_t;
  typedef logic [WIDTH_W-1:0] width_t;
  typedef logic [COND_W-1:0]  cond_t;

  // unused codes 10 to 15 give a zero result and no flag write
  localparam op_t OP_ADD  = 4'd0;
  localparam op_t OP_SUB  = 4'd1;
  localparam op_t OP_AND  = 4'd2;
  localparam op_t OP_OR   = 4'd3;
  localparam op_t OP_XOR  = 4'd4;
  localparam op_t OP_MOV  = 4'd5;
  localparam op_t OP_ZXT  = 4'd6;
  localparam op_t OP_SXT  = 4'd7;
  localparam op_t OP_CMOV = 4'd8;
  localparam op_t OP_CSET = 4'd9;

  localparam width_t W8  = 2'd0;
  localparam width_t W16 = 2'd1;
  localparam width_t W32 = 2'd2;
  localparam width_t W64 = 2'd3;

  // odd codes are the inverse of the even code below them
  localparam cond_t CC_Z   = 4'd0;
  localparam cond_t CC_NZ  = 4'd1;
  localparam cond_t CC_S   = 4'd2;
  localparam cond_t CC_NS  = 4'd3;
  localparam cond_t CC_UGT = 4'd4;
  localparam cond_t CC_ULE = 4'd5;
  localparam cond_t CC_UGE = 4'd6;
  localparam cond_t CC_ULT = 4'd7;
  localparam cond_t CC_SGT = 4'd8;
  localparam cond_t CC_SLE = 4'd9;
  localparam cond_t CC_SGE = 4'd10;
  localparam cond_t CC_SLT = 4'd11;
  localparam cond_t CC_O   = 4'd12;
  localparam cond_t CC_NO  = 4'd13;
  localparam cond_t CC_P   = 4'd14;
  localparam cond_t CC_NP  = 4'd15;

endpackage

//--- source/alu_result_select.sv
`timescale 1ns/1ps

module alu_result_select import alu_types_pkg::*, alu_ops_pkg::*; (
  input  op_t    op,
  input  width_t width,
  input  word_t  a,
  input  word_t  b,
  input  word_t  sum,
  input  logic   take,
  output word_t  result
);

  word_t raw;   // value before the width merge
  word_t ext;   // b extended from the source width
  logic  sext;
  logic  merge;

  assign sext = (op == OP_SXT);

  always_comb begin
    case (width)
      W8: begin
        ext = sext ? {{56{b[7]}}, b[7:0]} : {56'b0, b[7:0]};
      end
      W16: begin
        ext = sext ? {{48{b[15]}}, b[15:0]} : {48'b0, b[15:0]};
      end
      W32: begin
        ext = sext ? {{32{b[31]}}, b[31:0]} : {32'b0, b[31:0]};
      end
      default: begin
        ext = b;
      end
    endcase
  end

  always_comb begin
    raw   = '0;
    merge = 1'b1;
    case (op)
      OP_ADD,
      OP_SUB:  raw = sum;
      OP_AND:  raw = a & b;
      OP_OR:   raw = a | b;
      OP_XOR:  raw = a ^ b;
      OP_MOV:  raw = b;
      OP_CMOV: raw = take ? b : a; // only W32 and W64 issued
      OP_ZXT,
      OP_SXT: begin
        raw   = ext; // already full width
        merge = 1'b0;
      end
      OP_CSET: begin
        raw   = {63'b0, take};
        merge = 1'b0;
      end
      default: begin
        merge = 1'b0; // unused code gives a zero result
      end
    endcase
  end

  // W32 clears the upper half, narrower widths keep the rest of a
  always_comb begin
    result = raw;
    if (merge) begin
      case (width)
        W8:      result = {a[63:8], raw[7:0]};
        W16:     result = {a[63:16], raw[15:0]};
        W32:     result = {32'b0, raw[31:0]};
        default: result = raw;
      endcase
    end
  end

endmodule

//--- source/alu_retire_stage.sv
`timescale 1ns/1ps

module alu_retire_stage import alu_types_pkg::*, alu_ops_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  thread_t thread,
  input  logic    except,
  input  thread_t except_thread,
  input  op_t     op,
  input  width_t  width,
  input  word_t   result_d,
  input  carry_t  carry_d,
  input  ovf_t    ovf_d,
  output logic    out_valid,
  output word_t   result,
  output op_t     op_q,
  output width_t  width_q,
  output carry_t  carry_q,
  output ovf_t    ovf_q
);

  logic    except_q;        // exception seen last cycle
  thread_t except_thread_q;
  logic    kill;

  // same-thread exception now or one cycle ago
  assign kill = (except && except_thread == thread) ||
                (except_q && except_thread_q == thread);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      except_q  <= 1'b0;
    end else begin
      out_valid <= in_valid && !kill;
      except_q  <= except;
    end
  end

  // payload has meaning only with out_valid
  always_ff @(posedge clk) begin
    except_thread_q <= except_thread;
    result          <= result_d;
    op_q            <= op;
    width_q         <= width;
    carry_q         <= carry_d;
    ovf_q           <= ovf_d;
  end

endmodule

//--- source/alu_top.sv
`timescale 1ns/1ps

module alu_top import alu_types_pkg::*, alu_ops_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid,
  input  op_t     op,
  input  width_t  width,
  input  cond_t   cond,
  input  word_t   a,
  input  word_t   b,
  input  flags_t  flags_in,
  input  thread_t thread,
  input  logic    except,
  input  thread_t except_thread,
  output logic    out_valid,
  output word_t   result,
  output flags_t  flags_out,
  output logic    flags_we
);

  logic   sub;
  logic   take;
  word_t  sum;
  word_t  result_d;
  carry_t carry_d, carry_q;
  ovf_t   ovf_d, ovf_q;
  op_t    op_q;
  width_t width_q;

  assign sub = (op == OP_SUB);

  alu_adder adder0 (.a(a), .b(b), .sub(sub), .sum(sum), .carry(carry_d), .ovf(ovf_d));

  cond_eval cond0 (.flags(flags_in), .cond(cond), .take(take));

  alu_result_select sel0 (
    .op(op), .width(width), .a(a), .b(b), .sum(sum), .take(take), .result(result_d)
  );

  alu_retire_stage stage0 (
    .clk(clk), .rst(rst), .in_valid(in_valid), .thread(thread),
    .except(except), .except_thread(except_thread), .op(op), .width(width),
    .result_d(result_d), .carry_d(carry_d), .ovf_d(ovf_d),
    .out_valid(out_valid), .result(result), .op_q(op_q), .width_q(width_q),
    .carry_q(carry_q), .ovf_q(ovf_q)
  );

  flag_gen flags0 (
    .out_valid(out_valid), .op(op_q), .width(width_q), .result(result),
    .carry(carry_q), .ovf(ovf_q), .flags(flags_out), .flags_we(flags_we)
  );

endmodule

//--- source/alu_types_pkg.sv
package alu_types_pkg;

  localparam int WORD_W  = 64;
  localparam int FLAG_W  = 6;
  localparam int CARRY_W = 5;
  localparam int OVF_W   = 4;

  // operand and result word
  typedef logic [WORD_W-1:0] word_t;

  // status flags C O A S Z P from high to low
  typedef logic [FLAG_W-1:0] flags_t;

  localparam int FLAG_C = 5;
  localparam int FLAG_O = 4;
  localparam int FLAG_A = 3;
  localparam int FLAG_S = 2;
  localparam int FLAG_Z = 1;
  localparam int FLAG_P = 0;

  // carries out of bits 3, 7, 15, 31, 63
  typedef logic [CARRY_W-1:0] carry_t;

  localparam int CY_NIB = 0;
  localparam int CY_8   = 1;
  localparam int CY_16  = 2;
  localparam int CY_32  = 3;
  localparam int CY_64  = 4;

  // signed overflow per width indexed like the width code
  typedef logic [OVF_W-1:0] ovf_t;

  // hardware thread id
  typedef logic [0:0] thread_t;

endpackage

//--- source/cond_eval.sv
`timescale 1ns/1ps

module cond_eval import alu_types_pkg::*, alu_ops_pkg::*; (
  input  flags_t flags,
  input  cond_t  cond,
  output logic   take
);

  logic c, o, s, z, p;

  assign c = flags[FLAG_C];
  assign o = flags[FLAG_O];
  assign s = flags[FLAG_S];
  assign z = flags[FLAG_Z];
  assign p = flags[FLAG_P];

  always_comb begin
    case (cond)
      CC_Z:   take = z;
      CC_NZ:  take = ~z;
      CC_S:   take = s;
      CC_NS:  take = ~s;
      CC_UGT: take = ~(c | z);
      CC_ULE: take = c | z;
      CC_UGE: take = ~c;
      CC_ULT: take = c;
      CC_SGT: take = ~((s ^ o) | z); // less means S != O
      CC_SLE: take = (s ^ o) | z;
      CC_SGE: take = ~(s ^ o);
      CC_SLT: take = s ^ o;
      CC_O:   take = o;
      CC_NO:  take = ~o;
      CC_P:   take = p;
      CC_NP:  take = ~p;
    endcase
  end

endmodule

//--- source/flag_gen.sv
`timescale 1ns/1ps

module flag_gen import alu_types_pkg::*, alu_ops_pkg::*; (
  input  logic   out_valid,
  input  op_t    op,
  input  width_t width,
  input  word_t  result,
  input  carry_t carry,
  input  ovf_t   ovf,
  output flags_t flags,
  output logic   flags_we
);

  logic cy;
  logic ov;
  logic sign;
  logic zero;
  logic is_sub;
  logic arith;
  logic logic_op;

  // carry, sign and zero at the operand width
  always_comb begin
    case (width)
      W8: begin
        cy   = carry[CY_8];
        sign = result[7];
        zero = (result[7:0] == 8'b0);
      end
      W16: begin
        cy   = carry[CY_16];
        sign = result[15];
        zero = (result[15:0] == 16'b0);
      end
      W32: begin
        cy   = carry[CY_32];
        sign = result[31];
        zero = (result[31:0] == 32'b0);
      end
      default: begin
        cy   = carry[CY_64];
        sign = result[63];
        zero = (result == '0);
      end
    endcase
  end

  assign ov       = ovf[width];
  assign is_sub   = (op == OP_SUB);
  assign arith    = (op == OP_ADD) || is_sub;
  assign logic_op = (op == OP_AND) || (op == OP_OR) || (op == OP_XOR);

  always_comb begin
    flags         = '0; // C O A stay clear for logic ops
    flags[FLAG_S] = sign;
    flags[FLAG_Z] = zero;
    flags[FLAG_P] = ~^result[7:0];
    if (arith) begin
      flags[FLAG_C] = cy ^ is_sub; // borrow is the inverted carry
      flags[FLAG_A] = carry[CY_NIB] ^ is_sub;
      flags[FLAG_O] = ov;
    end
  end

  assign flags_we = out_valid && (arith || logic_op);

endmodule
